// ==== verilog/mii_rx_pkg.sv ====
// MII receive framing package: shared sizes, beat and host structs, opcodes and states
package mii_rx_pkg;

   localparam int NUM_SLOTS_DEF  = 4;
   localparam int SLOT_BYTES_DEF = 128;

   localparam logic [7:0]  SFD_BYTE     = 8'hD5;
   localparam logic [23:0] MCAST_PREFIX = 24'h01005E;   // IPv4 multicast OUI

   typedef enum logic [1:0] {
      BEAT_DATA,
      BEAT_COMMIT,
      BEAT_DISCARD
   } beat_kind_e;

   typedef struct packed {
      logic       valid;
      beat_kind_e kind;
      logic [7:0] data;
   } rx_beat_t;

   typedef struct packed {
      logic [47:0] mac_addr;
      logic        promiscuous;
      logic        rx_enable;
   } rx_cfg_t;

   typedef struct packed {
      logic        sel;
      logic        we;
      logic [9:0]  addr;    // Bit 9 selects the frame data window
      logic [31:0] wdata;
   } host_req_t;

   typedef enum logic [3:0] {
      REG_MAC_LO      = 4'd0,
      REG_MAC_HI_CTRL = 4'd1,
      REG_STATUS      = 4'd2,
      REG_HEAD_LEN    = 4'd3,
      REG_RELEASE     = 4'd4,
      REG_DROPS       = 4'd5
   } host_reg_e;

   typedef enum logic [1:0] {
      FR_IDLE,
      FR_PREAMBLE,
      FR_BODY,
      FR_DROP
   } framer_state_e;

endpackage

// ==== verilog/mii_rx_framer.sv ====
// MII receive framer: nibble to byte assembly, SFD search, address filter and slot credits
`timescale 1ns/1ps

module mii_rx_framer
#(
   parameter int NUM_SLOTS = mii_rx_pkg::NUM_SLOTS_DEF
)
(
   input  logic                 clk_mii,
   input  logic                 rstn,
   input  logic [3:0]           i_erxd,
   input  logic                 i_erx_dv,
   input  logic                 i_erx_er,
   input  mii_rx_pkg::rx_cfg_t  i_cfg,
   input  logic                 i_credit,
   output mii_rx_pkg::rx_beat_t o_beat,
   output logic                 o_drop
);
   import mii_rx_pkg::*;

   localparam int CW = $clog2(NUM_SLOTS + 1);

   framer_state_e state;
   logic [3:0]    rxd_q;
   logic          dv_q;
   logic          er_q;
   logic [3:0]    prev_nib;
   logic [3:0]    lo_nib;
   logic          hi_phase;
   logic [7:0]    byte_q;
   logic          byte_stb;
   logic [7:0]    data_q;
   logic          data_stb;
   logic [47:0]   dest_mac;
   logic [2:0]    dest_cnt;
   logic          er_seen;
   logic          end_stb;
   logic          end_d;
   logic [CW-1:0] credits;
   logic          sfd_hit;
   logic          spend;
   logic          addr_ok;
   logic          accept;
   logic          give_back;

   // Low nibble of D5 arrives first
   assign sfd_hit   = (state == FR_PREAMBLE) && dv_q && ({rxd_q, prev_nib} == SFD_BYTE);
   assign spend     = sfd_hit && i_cfg.rx_enable && (credits != '0);
   assign addr_ok   = (dest_mac == i_cfg.mac_addr) || (&dest_mac) ||
                      (dest_mac[47:24] == MCAST_PREFIX) || i_cfg.promiscuous;
   assign accept    = addr_ok && !er_seen && (dest_cnt == 3'd6);
   assign give_back = end_d && !accept;   // Discard hands the slot back

   always_ff @(posedge clk_mii)
   begin
      rxd_q    <= i_erxd;
      prev_nib <= rxd_q;
      if (!rstn)
      begin
         dv_q <= 1'b0;
         er_q <= 1'b0;
      end
      else
      begin
         dv_q <= i_erx_dv;
         er_q <= i_erx_er;
      end
   end

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         state    <= FR_IDLE;
         hi_phase <= 1'b0;
         byte_stb <= 1'b0;
         end_stb  <= 1'b0;
         er_seen  <= 1'b0;
         o_drop   <= 1'b0;
      end
      else
      begin
         byte_stb <= 1'b0;
         end_stb  <= 1'b0;
         o_drop   <= 1'b0;
         case (state)
            FR_IDLE:
               if (dv_q)
                  state <= FR_PREAMBLE;
            FR_PREAMBLE:
               if (!dv_q)
                  state <= FR_IDLE;
               else if (sfd_hit)
               begin
                  hi_phase <= 1'b0;
                  er_seen  <= 1'b0;
                  if (spend)
                     state <= FR_BODY;
                  else
                  begin
                     state  <= FR_DROP;
                     o_drop <= i_cfg.rx_enable;   // Counted only when out of credits
                  end
               end
            FR_BODY:
               if (!dv_q)
               begin
                  state   <= FR_IDLE;
                  end_stb <= 1'b1;
               end
               else
               begin
                  hi_phase <= !hi_phase;
                  byte_stb <= hi_phase;
                  er_seen  <= er_seen | er_q;
               end
            default:
               if (!dv_q)
                  state <= FR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_mii)
   begin
      if (state == FR_BODY && !hi_phase)
         lo_nib <= rxd_q;
      if (state == FR_BODY && hi_phase)
         byte_q <= {rxd_q, lo_nib};
   end

   // Destination capture, then the beat register
   always_ff @(posedge clk_mii)
   begin
      data_q <= byte_q;
      if (byte_stb && dest_cnt != 3'd6)
         dest_mac <= {dest_mac[39:0], byte_q};
      if (!rstn)
      begin
         data_stb <= 1'b0;
         end_d    <= 1'b0;
         dest_cnt <= 3'd0;
         o_beat   <= '0;
      end
      else
      begin
         data_stb <= byte_stb;
         end_d    <= end_stb;
         if (sfd_hit)
            dest_cnt <= 3'd0;
         else if (byte_stb && dest_cnt != 3'd6)
            dest_cnt <= dest_cnt + 3'd1;
         o_beat.valid <= data_stb || end_d;
         o_beat.kind  <= data_stb ? BEAT_DATA : (accept ? BEAT_COMMIT : BEAT_DISCARD);
         o_beat.data  <= data_stb ? data_q : 8'h00;
      end
   end

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
         credits <= CW'(NUM_SLOTS);
      else
         credits <= credits + CW'(i_credit) + CW'(give_back) - CW'(spend);
   end

   // Buffer returns exactly one credit per slot it frees
   a_credit_bound: assert property (@(posedge clk_mii) disable iff (!rstn)
      credits <= CW'(NUM_SLOTS))
      else $error("framer holds more credits than slots");

endmodule

// ==== verilog/rx_frame_buffer.sv ====
// Receive frame buffer: ring of frame slots with per-slot length and a head read port
`timescale 1ns/1ps

module rx_frame_buffer
#(
   parameter int NUM_SLOTS  = mii_rx_pkg::NUM_SLOTS_DEF,
   parameter int SLOT_BYTES = mii_rx_pkg::SLOT_BYTES_DEF
)
(
   input  logic                          clk_mii,
   input  logic                          rstn,
   input  mii_rx_pkg::rx_beat_t          i_beat,
   input  logic [$clog2(SLOT_BYTES)-1:0] i_rd_addr,
   input  logic                          i_release,
   output logic [7:0]                    o_rd_data,
   output logic [$clog2(SLOT_BYTES):0]   o_head_len,
   output logic                          o_avail,
   output logic [$clog2(NUM_SLOTS):0]    o_used,
   output logic                          o_credit
);
   import mii_rx_pkg::*;

   localparam int SW = $clog2(NUM_SLOTS);
   localparam int AW = $clog2(SLOT_BYTES);
   localparam int UW = SW + 1;

   logic [7:0]    mem [NUM_SLOTS*SLOT_BYTES];
   logic [AW:0]   len [NUM_SLOTS];
   logic [SW-1:0] head;
   logic [SW-1:0] tail;
   logic [UW-1:0] used;
   logic [AW:0]   wr_off;
   logic          ovf;
   logic          wr_data;
   logic          end_beat;
   logic          commit;
   logic          commit_ok;
   logic          ovf_commit;
   logic [1:0]    owed;
   logic [1:0]    owed_sum;

   assign wr_data    = i_beat.valid && (i_beat.kind == BEAT_DATA);
   assign end_beat   = i_beat.valid && (i_beat.kind != BEAT_DATA);
   assign commit     = i_beat.valid && (i_beat.kind == BEAT_COMMIT);
   assign commit_ok  = commit && !ovf;
   assign ovf_commit = commit && ovf;   // Oversized frame dies here, its slot is handed back
   assign owed_sum   = owed + 2'(i_release) + 2'(ovf_commit);

   always_ff @(posedge clk_mii)
   begin
      if (wr_data && !wr_off[AW])
         mem[{tail, wr_off[AW-1:0]}] <= i_beat.data;
      if (commit_ok)
         len[tail] <= wr_off;
   end

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         head     <= '0;
         tail     <= '0;
         used     <= '0;
         wr_off   <= '0;
         ovf      <= 1'b0;
         owed     <= 2'd0;
         o_credit <= 1'b0;
      end
      else
      begin
         if (end_beat)
         begin
            wr_off <= '0;
            ovf    <= 1'b0;
         end
         else if (wr_data)
         begin
            if (wr_off[AW])
               ovf <= 1'b1;
            else
               wr_off <= wr_off + 1'b1;
         end
         if (commit_ok)
            tail <= tail + 1'b1;
         if (i_release)
            head <= head + 1'b1;
         used <= used + UW'(commit_ok) - UW'(i_release);
         // Release and overflow can coincide, so keep a small backlog
         o_credit <= (owed_sum != 2'd0);
         owed     <= owed_sum - 2'(owed_sum != 2'd0);
      end
   end

   assign o_rd_data  = mem[{head, i_rd_addr}];
   assign o_avail    = (used != '0);
   assign o_head_len = o_avail ? len[head] : '0;
   assign o_used     = used;

   // Framer credits must keep commits within the ring
   a_commit_room: assert property (@(posedge clk_mii) disable iff (!rstn)
      commit |-> (used != UW'(NUM_SLOTS)))
      else $error("commit beat while every slot is full");

   a_release_held: assert property (@(posedge clk_mii) disable iff (!rstn)
      i_release |-> o_avail)
      else $error("release with no frame in the buffer");

endmodule

// ==== verilog/host_rx_port.sv ====
// Host port: register map, frame data window, slot release, drop count and interrupt
`timescale 1ns/1ps

module host_rx_port
#(
   parameter int NUM_SLOTS  = mii_rx_pkg::NUM_SLOTS_DEF,
   parameter int SLOT_BYTES = mii_rx_pkg::SLOT_BYTES_DEF
)
(
   input  logic                          clk_mii,
   input  logic                          rstn,
   input  mii_rx_pkg::host_req_t         i_host,
   input  logic                          i_avail,
   input  logic [$clog2(SLOT_BYTES):0]   i_head_len,
   input  logic [$clog2(NUM_SLOTS):0]    i_used,
   input  logic [7:0]                    i_rd_data,
   input  logic                          i_drop,
   output mii_rx_pkg::rx_cfg_t           o_cfg,
   output logic [$clog2(SLOT_BYTES)-1:0] o_rd_addr,
   output logic                          o_release,
   output logic [31:0]                   o_host_rdata,
   output logic                          o_eth_irq
);
   import mii_rx_pkg::*;

   localparam int AW = $clog2(SLOT_BYTES);

   logic [47:0] mac_addr;
   logic        rx_enable;
   logic        promiscuous;
   logic        irq_en;
   logic [15:0] drops;
   host_reg_e   reg_idx;
   logic        reg_wr;
   logic        host_rd;
   logic [31:0] reg_word;

   assign reg_idx   = host_reg_e'(i_host.addr[3:0]);
   assign reg_wr    = i_host.sel && i_host.we && !i_host.addr[9];
   assign host_rd   = i_host.sel && !i_host.we;
   assign o_release = reg_wr && (reg_idx == REG_RELEASE);
   assign o_rd_addr = i_host.addr[AW-1:0];

   assign o_cfg.mac_addr    = mac_addr;
   assign o_cfg.promiscuous = promiscuous;
   assign o_cfg.rx_enable   = rx_enable;

   always_comb
   begin
      case (reg_idx)
         REG_MAC_LO:      reg_word = mac_addr[31:0];
         REG_MAC_HI_CTRL: reg_word = {13'd0, irq_en, promiscuous, rx_enable, mac_addr[47:32]};
         REG_STATUS:      reg_word = {16'd0, 8'(i_used), 7'd0, i_avail};
         REG_HEAD_LEN:    reg_word = 32'(i_head_len);
         REG_DROPS:       reg_word = {16'd0, drops};
         default:         reg_word = 32'd0;
      endcase
   end

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         mac_addr     <= 48'h02_00_00_00_00_01;
         rx_enable    <= 1'b0;
         promiscuous  <= 1'b0;
         irq_en       <= 1'b0;
         drops        <= 16'd0;
         o_host_rdata <= 32'd0;
         o_eth_irq    <= 1'b0;
      end
      else
      begin
         if (reg_wr)
         begin
            case (reg_idx)
               REG_MAC_LO:
                  mac_addr[31:0] <= i_host.wdata;
               REG_MAC_HI_CTRL:
                  {irq_en, promiscuous, rx_enable, mac_addr[47:32]} <= i_host.wdata[18:0];
               default:
                  ;
            endcase
         end
         if (i_drop && drops != 16'hFFFF)
            drops <= drops + 16'd1;   // Saturates
         if (host_rd)
            o_host_rdata <= i_host.addr[9] ? {24'd0, i_rd_data} : reg_word;
         o_eth_irq <= i_avail && irq_en;
      end
   end

endmodule

// ==== verilog/mii_rx_top.sv ====
// MII receive top: framer feeding the frame buffer, drained through the host port
`timescale 1ns/1ps

module mii_rx_top
#(
   parameter int NUM_SLOTS  = mii_rx_pkg::NUM_SLOTS_DEF,
   parameter int SLOT_BYTES = mii_rx_pkg::SLOT_BYTES_DEF
)
(
   input  logic                  clk_mii,
   input  logic                  rstn,
   input  logic [3:0]            i_erxd,
   input  logic                  i_erx_dv,
   input  logic                  i_erx_er,
   input  mii_rx_pkg::host_req_t i_host,
   output logic [31:0]           o_host_rdata,
   output logic                  o_eth_irq
);
   import mii_rx_pkg::*;

   localparam int SW = $clog2(NUM_SLOTS);
   localparam int AW = $clog2(SLOT_BYTES);

   rx_beat_t    beat;
   rx_cfg_t     cfg;
   logic        credit;
   logic        drop;
   logic        slot_release;
   logic [AW-1:0] rd_addr;
   logic [7:0]  rd_data;
   logic [AW:0] head_len;
   logic        avail;
   logic [SW:0] used;

   mii_rx_framer #(
      .NUM_SLOTS  (NUM_SLOTS)
   ) u_framer (
      .clk_mii    (clk_mii),
      .rstn       (rstn),
      .i_erxd     (i_erxd),
      .i_erx_dv   (i_erx_dv),
      .i_erx_er   (i_erx_er),
      .i_cfg      (cfg),
      .i_credit   (credit),
      .o_beat     (beat),
      .o_drop     (drop)
   );

   rx_frame_buffer #(
      .NUM_SLOTS  (NUM_SLOTS),
      .SLOT_BYTES (SLOT_BYTES)
   ) u_buffer (
      .clk_mii    (clk_mii),
      .rstn       (rstn),
      .i_beat     (beat),
      .i_rd_addr  (rd_addr),
      .i_release  (slot_release),
      .o_rd_data  (rd_data),
      .o_head_len (head_len),
      .o_avail    (avail),
      .o_used     (used),
      .o_credit   (credit)
   );

   host_rx_port #(
      .NUM_SLOTS    (NUM_SLOTS),
      .SLOT_BYTES   (SLOT_BYTES)
   ) u_port (
      .clk_mii      (clk_mii),
      .rstn         (rstn),
      .i_host       (i_host),
      .i_avail      (avail),
      .i_head_len   (head_len),
      .i_used       (used),
      .i_rd_data    (rd_data),
      .i_drop       (drop),
      .o_cfg        (cfg),
      .o_rd_addr    (rd_addr),
      .o_release    (slot_release),
      .o_host_rdata (o_host_rdata),
      .o_eth_irq    (o_eth_irq)
   );

endmodule

// ==== verification/tb_mii_rx_tasks.svh ====
// Testbench tasks: MII frame sender, host register access, readback and expected frames

task automatic host_write(input logic [9:0] addr, input logic [31:0] data);
   @(posedge clk_mii);
   #1;
   host.sel   = 1'b1;
   host.we    = 1'b1;
   host.addr  = addr;
   host.wdata = data;
   @(posedge clk_mii);
   #1;
   host.sel = 1'b0;
   host.we  = 1'b0;
endtask

// Read data registers on the next edge and is compared one edge later
task automatic host_check(input logic [9:0] addr, input logic [31:0] exp);
   @(posedge clk_mii);
   #1;
   host.sel  = 1'b1;
   host.we   = 1'b0;
   host.addr = addr;
   @(posedge clk_mii);
   #1;
   host.sel = 1'b0;
   chk_exp  = exp;
   chk_rd   = 1'b1;
   n_checks++;
   @(posedge clk_mii);
   #1;
   chk_rd = 1'b0;
endtask

task automatic set_ctrl(input logic irq, input logic promisc, input logic en);
   host_write(REG_MAC_HI_CTRL, {13'd0, irq, promisc, en, mac_tb[47:32]});
   irq_en_tb  = irq;
   promisc_tb = promisc;
   rx_en_tb   = en;
endtask

task automatic send_nibble(input logic [3:0] nib, input logic er);
   erxd   = nib;
   erx_dv = 1'b1;
   erx_er = er;
   @(posedge clk_mii);
   #1;
endtask

// Destination goes out first, most significant byte leading
task automatic build_frame(input logic [47:0] dest, input int len);
   frm.delete();
   for (int i = 0; i < len; i++)
      frm.push_back(i < 6 ? dest[47 - 8 * i -: 8] : 8'($random(seed)));
endtask

task automatic send_frame(input int er_at);
   @(posedge clk_mii);
   #1;
   repeat (15) send_nibble(4'h5, 1'b0);
   send_nibble(4'hD, 1'b0);   // SFD high nibble
   foreach (frm[i])
   begin
      send_nibble(frm[i][3:0], i == er_at);
      send_nibble(frm[i][7:4], 1'b0);
   end
   erx_dv = 1'b0;
   erx_er = 1'b0;
   erxd   = 4'h0;
   repeat (12) @(posedge clk_mii);
   #1;
endtask

function automatic logic frame_kept(input logic [47:0] dest, input int len, input logic er);
   logic addr_match;
   addr_match = (dest == mac_tb) || (dest == 48'hFFFF_FFFF_FFFF) ||
                (dest[47:24] == 24'h01005E) || promisc_tb;
   return addr_match && !er && (len >= 6) && (len <= SLOT_BYTES);
endfunction

task automatic send_tracked(input logic [47:0] dest, input int len, input int er_at);
   build_frame(dest, len);
   send_frame(er_at);
   if (rx_en_tb)
   begin
      if (tb_used == NUM_SLOTS)
         exp_drops++;   // No credit left
      else if (frame_kept(dest, len, er_at >= 0))
      begin
         tb_used++;
         exp_lens.push_back(len);
         foreach (frm[i])
            exp_bytes.push_back(frm[i]);
      end
   end
endtask

task automatic read_frame();
   int len;
   len = exp_lens.pop_front();
   host_check(REG_HEAD_LEN, 32'(len));
   for (int i = 0; i < len; i++)
      host_check({1'b1, 9'(i)}, {24'd0, exp_bytes.pop_front()});
   host_write(REG_RELEASE, 32'd0);
   tb_used--;
endtask

task automatic check_status();
   host_check(REG_STATUS, {16'd0, 8'(tb_used), 7'd0, (tb_used != 0)});
endtask

task automatic check_irq(input logic exp);
   repeat (3) @(posedge clk_mii);
   #1;
   chk_irq_exp = exp;
   chk_irq     = 1'b1;
   n_checks++;
   @(posedge clk_mii);
   #1;
   chk_irq = 1'b0;
endtask

task automatic start_test(input string name);
   test_name = name;
   err_base  = n_errors;
endtask

task automatic end_test();
   n_tests++;
   $display("test %s %s, %0d errors", test_name, (n_errors == err_base) ? "ok" : "failed",
            n_errors - err_base);
endtask

// ==== verification/tb_mii_rx_top.sv ====
// Testbench for the MII receive path: frame stimulus, host readback checks and result line
`timescale 1ns/1ps

module tb_mii_rx_top;
   import mii_rx_pkg::*;

   localparam int NUM_SLOTS   = NUM_SLOTS_DEF;
   localparam int SLOT_BYTES  = SLOT_BYTES_DEF;
   localparam int FRAME_CYC   = 2 * (8 + SLOT_BYTES) + 24;   // Preamble, body and idle gap
   localparam int TIMEOUT_CYC = 20 * FRAME_CYC + 30 * 3 * SLOT_BYTES + 2560;

   logic        clk_mii;
   logic        rstn;
   logic [3:0]  erxd;
   logic        erx_dv;
   logic        erx_er;
   host_req_t   host;
   logic [31:0] host_rdata;
   logic        eth_irq;

   logic [7:0]  frm[$];
   logic [7:0]  exp_bytes[$];   // Accepted frames, oldest first
   int          exp_lens[$];
   logic [47:0] mac_tb;
   logic        promisc_tb;
   logic        rx_en_tb;
   logic        irq_en_tb;
   int          tb_used;
   int          exp_drops;
   integer      seed;
   string       test_name;
   int          err_base;
   int          n_errors;
   int          n_checks;
   int          n_tests;
   int          cycles;
   logic        chk_rd;
   logic [31:0] chk_exp;
   logic        chk_irq;
   logic        chk_irq_exp;

   mii_rx_top i_dut (
      .clk_mii      (clk_mii),
      .rstn         (rstn),
      .i_erxd       (erxd),
      .i_erx_dv     (erx_dv),
      .i_erx_er     (erx_er),
      .i_host       (host),
      .o_host_rdata (host_rdata),
      .o_eth_irq    (eth_irq)
   );

   `include "tb_mii_rx_tasks.svh"

   initial
   begin
      clk_mii = 1'b0;
      forever #2 clk_mii = ~clk_mii;
   end

   always @(posedge clk_mii)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYC)
      begin
         $display("run timed out after %0d cycles in test %s", cycles, test_name);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   a_read_value: assert property (@(posedge clk_mii) chk_rd |-> (host_rdata == chk_exp))
      else
      begin
         n_errors++;
         $display("ERROR %s: expected %h, actual %h", test_name, chk_exp, $sampled(host_rdata));
      end

   a_irq_value: assert property (@(posedge clk_mii) chk_irq |-> (eth_irq == chk_irq_exp))
      else
      begin
         n_errors++;
         $display("ERROR %s: expected irq %b, actual %b", test_name, chk_irq_exp,
                  $sampled(eth_irq));
      end

   // Register and output each need a cycle after irq_en drops
   a_irq_masked: assert property (@(posedge clk_mii) disable iff (!rstn)
      (!irq_en_tb && $past(!irq_en_tb)) |-> !eth_irq)
      else
      begin
         n_errors++;
         $display("ERROR %s: expected irq 0, actual 1", test_name);
      end

   initial
   begin
      seed        = 52;
      cycles      = 0;
      rstn        = 1'b0;
      erxd        = 4'h0;
      erx_dv      = 1'b0;
      erx_er      = 1'b0;
      host        = '0;
      chk_rd      = 1'b0;
      chk_exp     = 32'd0;
      chk_irq     = 1'b0;
      chk_irq_exp = 1'b0;
      mac_tb      = 48'h02_00_00_00_00_01;
      promisc_tb  = 1'b0;
      rx_en_tb    = 1'b0;
      irq_en_tb   = 1'b0;
      tb_used     = 0;
      exp_drops   = 0;
      n_errors    = 0;
      n_checks    = 0;
      n_tests     = 0;
      test_name   = "reset";
      repeat (16) @(posedge clk_mii);
      #1;
      rstn = 1'b1;

      start_test("reset");
      host_check(REG_MAC_LO, 32'h0000_0001);
      check_status();
      host_check(REG_DROPS, 32'd0);
      check_irq(1'b0);
      end_test();

      start_test("unicast");
      host_write(REG_MAC_LO, 32'h0000_ABCD);
      mac_tb[31:0] = 32'h0000_ABCD;
      set_ctrl(1'b0, 1'b0, 1'b1);
      send_tracked(48'h02_00_00_00_AB_CD, 64, -1);
      read_frame();
      send_tracked(48'h02_00_00_00_00_99, 32, -1);   // Foreign address
      check_status();
      end_test();

      start_test("filter");
      send_tracked(48'hFF_FF_FF_FF_FF_FF, 20, -1);
      send_tracked(48'h01_00_5E_00_00_FB, 30, -1);
      send_tracked(48'h0A_1B_2C_3D_4E_5F, 40, -1);
      set_ctrl(1'b0, 1'b1, 1'b1);
      send_tracked(48'h0A_1B_2C_3D_4E_5F, 40, -1);
      check_status();
      repeat (3) read_frame();
      set_ctrl(1'b0, 1'b0, 1'b1);
      end_test();

      start_test("errors");
      send_tracked(mac_tb, 30, 10);
      check_status();
      send_tracked(mac_tb, 4, -1);
      check_status();
      send_tracked(mac_tb, SLOT_BYTES + 12, -1);
      check_status();
      end_test();

      start_test("credits");
      for (int k = 0; k <= NUM_SLOTS; k++)
         send_tracked(mac_tb, 24 + k, -1);   // One more frame than slots
      check_status();
      host_check(REG_DROPS, 32'(exp_drops));
      read_frame();
      check_status();
      send_tracked(mac_tb, 50, -1);
      check_status();
      repeat (NUM_SLOTS) read_frame();
      check_status();
      end_test();

      start_test("irq");
      set_ctrl(1'b1, 1'b0, 1'b1);
      check_irq(1'b0);
      send_tracked(mac_tb, 30, -1);
      check_irq(1'b1);
      read_frame();
      check_irq(1'b0);
      set_ctrl(1'b0, 1'b0, 1'b1);
      send_tracked(mac_tb, 30, -1);
      check_irq(1'b0);
      read_frame();
      check_irq(1'b0);
      end_test();

      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+verification
verilog/mii_rx_pkg.sv
verilog/mii_rx_framer.sv
verilog/rx_frame_buffer.sv
verilog/host_rx_port.sv
verilog/mii_rx_top.sv
verification/tb_mii_rx_top.sv

// ==== Bender.yml ====
package:
  name: mii_rx

sources:
  - files:
      - verilog/mii_rx_pkg.sv
      - verilog/mii_rx_framer.sv
      - verilog/rx_frame_buffer.sv
      - verilog/host_rx_port.sv
      - verilog/mii_rx_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_mii_rx_top.sv
